// File: logic/alu_consts.svh
// word, accumulator, result queue and booth step constants for the arithmetic unit

`ifndef ALU_CONSTS_SVH
`define ALU_CONSTS_SVH

// operand and result word width, two's complement
`define ALU_WORD_W 8

// accumulator width: word plus two guard bits so that +-2M fits
`define ALU_ACC_W (`ALU_WORD_W + 2)

// result queue entries
`define ALU_FIFO_DEPTH 4

// radix-4 booth iterations, two multiplier bits per step
`define ALU_R4_STEPS (`ALU_WORD_W / 2)

`endif

// File: logic/alu_ctrl_if.sv
// control strobes and status between the sequencer and the datapath
`timescale 1ns/1ps
`default_nettype none

interface alu_ctrl_if;

    // strobes from the sequencer, acted on at the next rising clk edge
    logic       load_a;             // A from inbus, sign extended
    logic       load_q;             // Q from inbus, Q[-1] cleared
    logic       load_m;             // M from inbus
    logic       init_a;             // clear A before a multiply
    logic       load_a_from_adder;  // A from the adder output
    logic       rshift;             // one-bit arithmetic shift of A:Q:Q[-1]
    logic       init_count;         // clear the booth step counter
    logic       inc_count;
    logic       sel_sub;            // adder subtracts
    logic       sel_2m;             // adder uses 2M instead of M
    logic       push_a;             // push low byte of A into the queue
    logic       push_q;             // push Q into the queue

    // status from the datapath
    logic [2:0] booth_bits;         // Q[1], Q[0], Q[-1]
    logic       count_full;         // last booth step reached

    modport seq (
        output load_a, load_q, load_m, init_a, load_a_from_adder, rshift,
        output init_count, inc_count, sel_sub, sel_2m, push_a, push_q,
        input  booth_bits, count_full
    );

    modport dp (
        input  load_a, load_q, load_m, init_a, load_a_from_adder, rshift,
        input  init_count, inc_count, sel_sub, sel_2m, push_a, push_q,
        output booth_bits, count_full
    );

endinterface

`default_nettype wire

// File: logic/alu_datapath.sv
// A, Q, M and Q[-1] registers, booth adder, two-step shifter and step counter
`timescale 1ns/1ps
`default_nettype none
`include "alu_consts.svh"

module alu_datapath (
    input  wire                          clk,
    input  wire                          arst_n,
    input  wire [`ALU_WORD_W-1:0]        inbus,
    alu_ctrl_if.dp                       ctrl,
    output logic                         push,
    output alu_pkg::result_word_t        push_word
);

    import alu_pkg::*;

    localparam int WW = `ALU_WORD_W;
    localparam int AW = `ALU_ACC_W;
    localparam int CW = $clog2(`ALU_R4_STEPS);

    logic [AW-1:0] a_reg;   // accumulator with two guard bits
    logic [WW-1:0] q_reg;   // multiplier, ends as product low byte
    logic [WW-1:0] m_reg;   // second operand / multiplicand
    logic          q_m1;    // Q[-1]
    logic [CW-1:0] count;   // booth steps done
    logic          is_mul;  // set by a Q load, cleared by an A load
    logic [AW-1:0] m_ext;
    logic [AW-1:0] addend;
    logic [AW-1:0] sum;
    result_word_t  word_c;

    // adder: A +- M or A +- 2M, all sign extended to the accumulator width
    assign m_ext  = {{(AW-WW){m_reg[WW-1]}}, m_reg};
    assign addend = ctrl.sel_2m ? {m_ext[AW-2:0], 1'b0} : m_ext;
    assign sum    = ctrl.sel_sub ? (a_reg - addend) : (a_reg + addend);

    // accumulator
    always_ff @(posedge clk) begin
        if (ctrl.init_a) begin
            a_reg <= '0;
        end else if (ctrl.load_a) begin
            a_reg <= {{(AW-WW){inbus[WW-1]}}, inbus};  // sign extend
        end else if (ctrl.load_a_from_adder) begin
            a_reg <= sum;
        end else if (ctrl.rshift) begin
            a_reg <= {a_reg[AW-1], a_reg[AW-1:1]};     // arithmetic
        end
    end

    // Q and Q[-1], fed from the bottom of A when shifting
    always_ff @(posedge clk) begin
        if (ctrl.load_q) begin
            q_reg <= inbus;
            q_m1  <= 1'b0;
        end else if (ctrl.rshift) begin
            q_reg <= {a_reg[0], q_reg[WW-1:1]};
            q_m1  <= q_reg[0];
        end
    end

    always_ff @(posedge clk) begin
        if (ctrl.load_m) begin
            m_reg <= inbus;
        end
    end

    // step counter and op type
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            count  <= '0;
            is_mul <= 1'b0;
        end else begin
            if (ctrl.init_count) begin
                count <= '0;
            end else if (ctrl.inc_count) begin
                count <= count + 1'b1;
            end
            if (ctrl.load_q) begin
                is_mul <= 1'b1;
            end else if (ctrl.load_a) begin
                is_mul <= 1'b0;
            end
        end
    end

    assign ctrl.booth_bits = {q_reg[1:0], q_m1};
    assign ctrl.count_full = (count == CW'(`ALU_R4_STEPS - 1));  // three for 8-bit words

    // result word: A low byte is the add/sub result or the product high byte
    always_comb begin
        word_c.data = ctrl.push_q ? q_reg : a_reg[WW-1:0];
        word_c.last = ctrl.push_q | (ctrl.push_a & ~is_mul);  // mul ends on Q
    end

    assign push      = ctrl.push_a | ctrl.push_q;
    assign push_word = word_c;

endmodule

`default_nettype wire

// File: logic/alu_pkg.sv
// operation codes, one-hot state indices and the result word type
`default_nettype none

package alu_pkg;

    `include "alu_consts.svh"

    // operation code as seen on the op input
    typedef enum logic [1:0] {
        OP_ADD  = 2'b00,  // 8-bit wrapped sum
        OP_SUB  = 2'b01,  // 8-bit wrapped difference
        OP_MUL  = 2'b10,  // radix-4 booth, 16-bit product
        OP_RSVD = 2'b11   // old division code, does nothing
    } alu_op_e;

    // bit position of each state inside the one-hot state register
    typedef enum logic [3:0] {
        IDLE          = 4'd0,
        LOADA         = 4'd1,  // A from inbus
        LOADQ         = 4'd2,  // Q from inbus, A cleared
        LOADM         = 4'd3,  // M from inbus, counter cleared
        ADDMTOA       = 4'd4,  // A := A +- M or A +- 2M
        RSHIFT        = 4'd5,  // first half of the two-bit shift
        RSHIFT_DOUBLE = 4'd6,  // second half
        COUNTRSHIFTS  = 4'd7,  // step counter increment
        PUSHA         = 4'd8,
        PUSHQ         = 4'd9
    } seq_state_e;

    // one queue entry; last marks the final word of an operation
    typedef struct packed {
        logic [`ALU_WORD_W-1:0] data;
        logic                   last;
    } result_word_t;

endpackage

`default_nettype wire

// File: logic/alu_sequencer.sv
// one-hot sequencer for add, sub and radix-4 booth multiply, with queue stall
`timescale 1ns/1ps
`default_nettype none

module alu_sequencer (
    input  wire                    clk,
    input  wire                    arst_n,
    input  wire                    op_begin,   // start strobe, only seen in IDLE
    input  wire alu_pkg::alu_op_e  op,
    input  wire                    fifo_full,
    output logic                   done,
    alu_ctrl_if.seq                ctrl
);

    import alu_pkg::*;

    localparam int NUM_STATES = PUSHQ + 1;  // one flop per state

    logic [NUM_STATES-1:0] state;      // current state, exactly one bit set
    logic [NUM_STATES-1:0] nxt;        // next state
    alu_op_e               op_q;       // op captured with begin
    logic                  is_mul;
    logic                  is_addsub;
    logic                  start_ok;   // begin in IDLE with a usable op
    logic                  booth_add;  // booth digit is not zero
    logic                  booth_neg;  // booth digit is negative
    logic                  booth_two;  // booth digit is +-2
    logic                  step_head;  // about to evaluate a booth step

    assign is_mul    = (op_q == OP_MUL);
    assign is_addsub = (op_q == OP_ADD) || (op_q == OP_SUB);
    assign start_ok  = state[IDLE] & op_begin & (op != OP_RSVD);  // rsvd just stays idle

    // booth recoding of Q[1] Q[0] Q[-1]
    assign booth_add = ~((&ctrl.booth_bits) | ~(|ctrl.booth_bits));  // 000 and 111 skip the add
    assign booth_neg = ctrl.booth_bits[2];
    assign booth_two = (ctrl.booth_bits == 3'b011) | (ctrl.booth_bits == 3'b100);

    // first step comes straight after LOADM, the others after the counter bump
    assign step_head = (state[LOADM] & is_mul) | state[COUNTRSHIFTS];

    // state flops, only IDLE comes out of reset set
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state       <= '0;
            state[IDLE] <= 1'b1;
            op_q        <= OP_ADD;
        end else begin
            state <= nxt;
            if (start_ok) begin
                op_q <= op;  // held for the whole operation
            end
        end
    end

    // next-state terms, one equation per state bit
    always_comb begin
        nxt = '0;

        nxt[IDLE] = (state[IDLE] & ~start_ok)                 // waiting, or rsvd op
                  | (state[PUSHA] & is_addsub & ~fifo_full)   // add/sub end
                  | (state[PUSHQ] & ~fifo_full);              // mul end

        nxt[LOADA] = start_ok & (op != OP_MUL);  // add, sub
        nxt[LOADQ] = start_ok & (op == OP_MUL);
        nxt[LOADM] = state[LOADA] | state[LOADQ];

        nxt[ADDMTOA] = (state[LOADM] & is_addsub)
                     | (step_head & booth_add);

        nxt[RSHIFT] = (state[ADDMTOA] & is_mul)   // after the partial add
                    | (step_head & ~booth_add);   // digit 0, shift at once
        nxt[RSHIFT_DOUBLE] = state[RSHIFT];
        nxt[COUNTRSHIFTS]  = state[RSHIFT_DOUBLE] & ~ctrl.count_full;

        // push states hold themselves while the queue is full
        nxt[PUSHA] = (state[ADDMTOA] & is_addsub)
                   | (state[RSHIFT_DOUBLE] & ctrl.count_full)
                   | (state[PUSHA] & fifo_full);
        nxt[PUSHQ] = (state[PUSHA] & is_mul & ~fifo_full)
                   | (state[PUSHQ] & fifo_full);
    end

    // load and init strobes line up with the edge that enters their state
    assign ctrl.load_a     = nxt[LOADA];
    assign ctrl.load_q     = nxt[LOADQ];
    assign ctrl.init_a     = nxt[LOADQ];   // product builds up from zero
    assign ctrl.load_m     = nxt[LOADM];
    assign ctrl.init_count = nxt[LOADM];

    assign ctrl.load_a_from_adder = nxt[ADDMTOA];
    assign ctrl.rshift            = nxt[RSHIFT] | nxt[RSHIFT_DOUBLE];  // two single shifts
    assign ctrl.inc_count         = nxt[COUNTRSHIFTS];

    // adder controls, booth bits are still the pre-add ones here
    assign ctrl.sel_sub = nxt[ADDMTOA] & (is_mul ? booth_neg : (op_q == OP_SUB));
    assign ctrl.sel_2m  = nxt[ADDMTOA] & is_mul & booth_two;

    // a push fires once, on the cycle the queue has room
    assign ctrl.push_a = state[PUSHA] & ~fifo_full;
    assign ctrl.push_q = state[PUSHQ] & ~fifo_full;

    // end of operation, high on the edge that re-enters IDLE
    assign done = nxt[IDLE] & ~state[IDLE];

endmodule

`default_nettype wire

// File: logic/alu_top.sv
// top level: sequencer, datapath, result queue and output port on plain ports
`timescale 1ns/1ps
`default_nettype none
`include "alu_consts.svh"

module alu_top (
    input  wire                    clk,
    input  wire                    arst_n,
    input  wire                    op_begin,   // start strobe
    input  wire [1:0]              op,         // 00 add, 01 sub, 10 mul, 11 reserved
    input  wire [`ALU_WORD_W-1:0]  inbus,      // operands, one per cycle
    input  wire                    out_take,
    output logic                   done,
    output logic [`ALU_WORD_W-1:0] out_data,
    output logic                   out_last,
    output logic                   out_valid
);

    import alu_pkg::*;

    alu_ctrl_if   ctrl ();     // sequencer to datapath

    logic         push;        // datapath into queue
    result_word_t push_word;
    logic         pop;         // port out of queue
    result_word_t pop_word;
    logic         fifo_full;
    logic         fifo_empty;

    alu_sequencer u_seq (
        .clk       (clk),
        .arst_n    (arst_n),
        .op_begin  (op_begin),
        .op        (alu_op_e'(op)),
        .fifo_full (fifo_full),
        .done      (done),
        .ctrl      (ctrl.seq)
    );

    alu_datapath u_dp (
        .clk       (clk),
        .arst_n    (arst_n),
        .inbus     (inbus),
        .ctrl      (ctrl.dp),
        .push      (push),
        .push_word (push_word)
    );

    result_fifo u_fifo (
        .clk       (clk),
        .arst_n    (arst_n),
        .push      (push),
        .push_word (push_word),
        .pop       (pop),
        .pop_word  (pop_word),
        .full      (fifo_full),
        .empty     (fifo_empty)
    );

    outbus_port u_port (
        .clk       (clk),
        .arst_n    (arst_n),
        .empty     (fifo_empty),
        .pop_word  (pop_word),
        .pop       (pop),
        .out_take  (out_take),
        .out_data  (out_data),
        .out_last  (out_last),
        .out_valid (out_valid)
    );

endmodule

`default_nettype wire

// File: logic/outbus_port.sv
// output holding register that shows the queue head until it is taken
`timescale 1ns/1ps
`default_nettype none
`include "alu_consts.svh"

module outbus_port (
    input  wire                        clk,
    input  wire                        arst_n,
    input  wire                        empty,      // queue has nothing
    input  wire alu_pkg::result_word_t pop_word,   // queue head
    output logic                       pop,
    input  wire                        out_take,   // one pulse per word
    output logic [`ALU_WORD_W-1:0]     out_data,
    output logic                       out_last,
    output logic                       out_valid
);

    import alu_pkg::*;

    result_word_t hold;  // word on the output pins

    // refill when the register is free or is being emptied this cycle
    assign pop = ~empty & (~out_valid | out_take);

    always_ff @(posedge clk) begin
        if (pop) begin
            hold <= pop_word;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid <= 1'b0;
        end else if (pop) begin
            out_valid <= 1'b1;   // new word, or back-to-back replacement
        end else if (out_take) begin
            out_valid <= 1'b0;
        end
    end

    assign out_data = hold.data;
    assign out_last = hold.last;

endmodule

`default_nettype wire

// File: logic/result_fifo.sv
// circular result queue with push/pop strobes and full/empty flags
`timescale 1ns/1ps
`default_nettype none
`include "alu_consts.svh"

module result_fifo (
    input  wire                    clk,
    input  wire                    arst_n,
    input  wire                    push,
    input  wire alu_pkg::result_word_t push_word,
    input  wire                    pop,
    output alu_pkg::result_word_t  pop_word,
    output logic                   full,
    output logic                   empty
);

    import alu_pkg::*;

    localparam int DEPTH = `ALU_FIFO_DEPTH;
    localparam int PW    = $clog2(DEPTH);

    result_word_t  mem [DEPTH];  // storage
    logic [PW-1:0] wr_ptr;
    logic [PW-1:0] rd_ptr;
    logic [PW:0]   count;        // entries held, 0..DEPTH
    logic          do_push;
    logic          do_pop;

    assign do_push = push & ~full;   // overflow never writes
    assign do_pop  = pop & ~empty;

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_word;
        end
    end

    // pointers wrap at DEPTH, count tracks simultaneous push and pop
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == PW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (do_push & ~do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop & ~do_push) begin
                count <= count - 1'b1;
            end
        end
    end

    assign pop_word = mem[rd_ptr];  // head, no read latency
    assign full     = (count == (PW+1)'(DEPTH));
    assign empty    = (count == '0);

endmodule

`default_nettype wire

// File: tb.f
+incdir+logic
logic/alu_pkg.sv
logic/alu_ctrl_if.sv
logic/alu_sequencer.sv
logic/alu_datapath.sv
logic/result_fifo.sv
logic/outbus_port.sv
logic/alu_top.sv
test/alu_assertions.sv
test/alu_tb.sv

// File: test/alu_assertions.sv
// concurrent checks on the one-hot state, queue pushes and the done pulse
`timescale 1ns/1ps
`default_nettype none

module alu_seq_assertions #(
    parameter bit SEQ_SIDE = 1'b1  // 1: state and done checks, 0: queue push check
) (
    input wire                    clk,
    input wire                    arst_n,
    input wire [alu_pkg::PUSHQ:0] state,  // one-hot state register
    input wire                    done,
    input wire                    push,   // queue write strobe
    input wire                    full    // queue full flag
);

    int fail_cnt;  // failed assertion count, read by the testbench

    generate
        if (SEQ_SIDE) begin : g_seq
            // exactly one state flop set at every edge
            a_one_hot: assert property (@(posedge clk) disable iff (!arst_n) $onehot(state))
                else begin
                    fail_cnt++;
                    $error("state register not one-hot: %b", state);
                end

            // done is a single-cycle pulse
            a_done_pulse: assert property (@(posedge clk) disable iff (!arst_n) done |=> !done)
                else begin
                    fail_cnt++;
                    $error("done high for two cycles in a row");
                end
        end else begin : g_queue
            // a full queue never sees a push from the datapath
            a_no_push_full: assert property (@(posedge clk) disable iff (!arst_n)
                                             !(push && full))
                else begin
                    fail_cnt++;
                    $error("push while the result queue is full");
                end
        end
    endgenerate

endmodule

// sequencer side: state register and done pulse
bind alu_sequencer alu_seq_assertions #(.SEQ_SIDE(1'b1)) u_seq_chk (
    .clk    (clk),
    .arst_n (arst_n),
    .state  (state),
    .done   (done),
    .push   (1'b0),
    .full   (1'b0)
);

// queue side: pushes as they arrive at the queue
bind result_fifo alu_seq_assertions #(.SEQ_SIDE(1'b0)) u_fifo_chk (
    .clk    (clk),
    .arst_n (arst_n),
    .state  ('0),
    .done   (1'b0),
    .push   (push),
    .full   (full)
);

`default_nettype wire

// File: test/alu_tb.sv
// testbench for alu_top: stimulus table, reference model, output reader, watchdog
`timescale 1ns/1ps
`default_nettype none
`include "alu_consts.svh"

module alu_tb;

    import alu_pkg::*;

    localparam int WW         = `ALU_WORD_W;
    localparam int N_DIRECTED = 16;
    localparam int BP_FIRST   = 12;   // rows from here on run with the reader stalled
    localparam int N_RANDOM   = 12;
    localparam int N_ROWS     = N_DIRECTED + N_RANDOM;
    localparam int HOLD_CYC   = 100;  // reader stall in the back-pressure phase

    logic          clk;
    logic          arst_n;
    logic          op_begin;
    logic [1:0]    op;
    logic [WW-1:0] inbus;
    logic          out_take;
    logic          done;
    logic [WW-1:0] out_data;
    logic          out_last;
    logic          out_valid;

    // stimulus table, expected result filled in by the model when a row is added
    alu_op_e       t_op    [N_ROWS];
    logic [WW-1:0] t_a     [N_ROWS];
    logic [WW-1:0] t_b     [N_ROWS];
    int            t_delay [N_ROWS];  // reader wait before each take
    logic [15:0]   t_exp   [N_ROWS];

    logic [WW-1:0] exp_data  [$];     // words still owed, in issue order
    logic          exp_last  [$];
    int            exp_delay [$];

    integer seed = 70831;
    int     n_built;
    int     value_errors;
    int     other_errors;
    int     assert_errors;
    int     n_checks;
    int     done_cnt;
    int     wait_cnt;
    bit     hold_take;                // reader withholds out_take

    alu_top i_dut (
        .clk       (clk),
        .arst_n    (arst_n),
        .op_begin  (op_begin),
        .op        (op),
        .inbus     (inbus),
        .out_take  (out_take),
        .done      (done),
        .out_data  (out_data),
        .out_last  (out_last),
        .out_valid (out_valid)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;  // 8 ns period

    // reference: wrapped sum and difference, full signed product
    function automatic logic [15:0] model_result(alu_op_e o, logic [WW-1:0] a, logic [WW-1:0] b);
        logic signed [15:0] prod;
        prod = $signed(a) * $signed(b);
        case (o)
            OP_ADD:  model_result = {8'h00, a + b};
            OP_SUB:  model_result = {8'h00, a - b};
            OP_MUL:  model_result = prod;
            default: model_result = 16'h0000;  // reserved gives nothing
        endcase
    endfunction

    task automatic check_value(input string name, input logic [15:0] expected,
                               input logic [15:0] actual);
        n_checks++;
        if (actual !== expected) begin
            $display("[FAIL] t=%0t %s expected=%0h actual=%0h", $time, name, expected, actual);
            value_errors++;
        end
    endtask

    task automatic add_row(input alu_op_e o, input logic [WW-1:0] a, input logic [WW-1:0] b,
                           input int d);
        t_op[n_built]    = o;
        t_a[n_built]     = a;
        t_b[n_built]     = b;
        t_delay[n_built] = d;
        t_exp[n_built]   = model_result(o, a, b);
        n_built++;
    endtask

    // words a row must produce: one for add/sub, high then low byte for mul
    task automatic queue_expected(input int i);
        if (t_op[i] == OP_MUL) begin
            exp_data.push_back(t_exp[i][15:8]);
            exp_last.push_back(1'b0);
            exp_delay.push_back(t_delay[i]);
        end
        if (t_op[i] != OP_RSVD) begin
            exp_data.push_back(t_exp[i][7:0]);
            exp_last.push_back(1'b1);
            exp_delay.push_back(t_delay[i]);
        end
    endtask

    // begin cycle carries the first operand, the next cycle carries M
    task automatic run_row(input int i, input bit check_lat);
        int lat;
        @(negedge clk);
        op_begin = 1'b1;
        op       = t_op[i];
        inbus    = t_a[i];
        queue_expected(i);
        @(negedge clk);
        op_begin = 1'b0;
        inbus    = t_b[i];
        lat      = 1;                 // begin edge already passed
        if (t_op[i] == OP_RSVD) begin
            repeat (6) begin
                check_value("done", 16'd0, 16'(done));
                @(negedge clk);
            end
        end else begin
            while (!done && lat < 400) begin
                @(negedge clk);
                lat++;
            end
            if (!done) begin
                $display("ERROR: row %0d never signalled done", i);
                other_errors++;
            end else if (check_lat && t_op[i] != OP_MUL) begin
                check_value("done_latency", 16'd4, 16'(lat));
            end
        end
    endtask

    task automatic wait_drain(input int limit);
        int n;
        n = 0;
        while (exp_data.size() != 0 && n < limit) begin
            @(negedge clk);
            n++;
        end
        if (exp_data.size() != 0) begin
            $display("ERROR: %0d expected words never came out", exp_data.size());
            other_errors++;
        end
    endtask

    always @(negedge clk) begin
        if (done) done_cnt++;  // done is one cycle wide
    end

    // reader: takes each word after its row's delay and checks it
    always @(negedge clk) begin
        if (!arst_n || !out_valid) begin
            out_take = 1'b0;
            wait_cnt = 0;
        end else if (exp_data.size() == 0) begin
            $display("ERROR: t=%0t unexpected output word %0h", $time, out_data);
            other_errors++;
            out_take = 1'b1;          // drain it
        end else if (!hold_take && wait_cnt >= exp_delay[0]) begin
            check_value("out_data", 16'(exp_data[0]), 16'(out_data));
            check_value("out_last", 16'(exp_last[0]), 16'(out_last));
            void'(exp_data.pop_front());
            void'(exp_last.pop_front());
            void'(exp_delay.pop_front());
            out_take = 1'b1;          // taken at the next rising edge
            wait_cnt = 0;
        end else begin
            out_take = 1'b0;
            wait_cnt++;
        end
    end

    // watchdog, 60 cycles per row
    initial begin
        #(N_ROWS * 60 * 8);
        $display("ERROR: run did not finish within %0d ns, DUT stopped responding",
                 N_ROWS * 60 * 8);
        $display("FAIL: see errors above");
        $finish;
    end

    initial begin
        int base;
        arst_n   = 1'b0;
        op_begin = 1'b0;
        op       = 2'b00;
        inbus    = '0;
        out_take = 1'b0;
        n_built  = 0;
        add_row(OP_ADD, 8'h05, 8'h03, 0);
        add_row(OP_ADD, 8'h7f, 8'h01, 0);  // overflow wraps to -128
        add_row(OP_ADD, 8'h80, 8'hff, 1);
        add_row(OP_SUB, 8'h03, 8'h05, 0);
        add_row(OP_SUB, 8'h80, 8'h01, 2);
        add_row(OP_MUL, 8'h80, 8'h80, 0);  // -128 x -128
        add_row(OP_MUL, 8'h80, 8'h7f, 1);
        add_row(OP_MUL, 8'h00, 8'h55, 0);
        add_row(OP_MUL, 8'h01, 8'hff, 0);
        add_row(OP_MUL, 8'hff, 8'hff, 3);
        add_row(OP_RSVD, 8'h12, 8'h34, 0);
        add_row(OP_SUB, 8'h10, 8'h20, 0);  // right after the reserved op
        add_row(OP_MUL, 8'h7f, 8'h7f, 0);  // back-pressure group
        add_row(OP_MUL, 8'hc3, 8'h25, 0);
        add_row(OP_MUL, 8'h81, 8'h02, 1);
        add_row(OP_ADD, 8'h40, 8'h41, 0);
        repeat (N_RANDOM) begin
            int r;
            r = $random(seed);
            add_row(alu_op_e'(r[1:0]), WW'($random(seed)), WW'($random(seed)), int'(r[3:2]));
        end

        repeat (8) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        repeat (5) begin
            @(negedge clk);
            check_value("out_valid", 16'd0, 16'(out_valid));
            check_value("done", 16'd0, 16'(done));
        end

        for (int i = 0; i < BP_FIRST; i++) run_row(i, 1'b1);
        wait_drain(200);

        // queue 4 deep plus the port register hold five words, so two muls finish
        base      = done_cnt;
        hold_take = 1'b1;
        fork
            for (int j = BP_FIRST; j < N_DIRECTED; j++) run_row(j, 1'b0);
            begin
                repeat (HOLD_CYC) @(negedge clk);
                check_value("done_count_while_stalled", 16'd2, 16'(done_cnt - base));
                hold_take = 1'b0;
            end
        join
        wait_drain(200);

        for (int i = N_DIRECTED; i < N_ROWS; i++) run_row(i, 1'b1);
        wait_drain(200);
        repeat (10) @(negedge clk);   // nothing extra may show up

        // failed concurrent assertions in the bound checkers
        assert_errors = i_dut.u_seq.u_seq_chk.fail_cnt + i_dut.u_fifo.u_fifo_chk.fail_cnt;
        $display("checks=%0d value_errors=%0d other_errors=%0d assert_errors=%0d", n_checks,
                 value_errors, other_errors, assert_errors);
        if (value_errors == 0 && other_errors == 0 && assert_errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire
